/* project.f */
logic/rv32i_pkg.sv
logic/control_unit.sv
logic/alu.sv
logic/reg_file.sv
logic/pc_unit.sv
logic/data_ram.sv
logic/rv32i_core.sv
tb/clock_gen.sv
tb/rv32i_core_sva.sv
tb/tb_rv32i_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv32i_core
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* tb/tb_rv32i_core.sv */
`timescale 1ns/1ps

module tb_rv32i_core import rv32i_pkg::*; ();

    localparam logic [WORD_W-1:0] RESET_PC   = 32'h0000_0000;
    localparam int                DMEM_WORDS = 256;
    localparam int                SEED       = 32'h4696435d;
    localparam int                MAX_GAP    = 3;
    localparam int                N_ALU      = 200;
    localparam int                N_JMP      = 20;
    localparam int                N_BR       = 10;
    localparam int                N_MEM      = 40;
    localparam int                N_ILL      = 10;
    // Register setup, all tests, the halt and the instructions sent after it
    localparam int N_INSTR = 62 + N_ALU + 4 * N_JMP + 6 * N_BR + 2 * N_MEM + 2
                           + 2 * N_ILL + 6;
    localparam time RUN_LIMIT = (N_INSTR * (1 + MAX_GAP) + 50) * 40ns;

    typedef struct packed {
        logic [WORD_W-1:0]     pc;
        logic [WORD_W-1:0]     instr;
        logic                  wen;
        logic [REG_ADDR_W-1:0] rd;
        logic [WORD_W-1:0]     data;
        logic                  illegal;
        logic                  halt;
    } exp_t;

    logic                  clk, rst_n;
    logic                  instr_valid_i;
    logic [WORD_W-1:0]     instr_i;
    logic                  retire_o, wb_en_o, illegal_o, halt_o;
    logic [WORD_W-1:0]     retire_pc_o, retire_instr_o, wb_data_o, pc_o;
    logic [REG_ADDR_W-1:0] wb_rd_o;

    // Reference state
    logic [WORD_W-1:0] m_regs [32];
    logic [WORD_W-1:0] m_mem [DMEM_WORDS];
    logic [WORD_W-1:0] m_pc;
    logic              m_halted;
    exp_t              exp_q [$];
    int                errors;

    clock_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    rv32i_core #(
        .RESET_PC(RESET_PC), .DMEM_WORDS(DMEM_WORDS), .INFINITE_LOOP_HALTS(1'b1)
    ) UUT (
        .CLK(clk), .rst_n_i(rst_n), .instr_valid_i(instr_valid_i), .instr_i(instr_i),
        .retire_o(retire_o), .retire_pc_o(retire_pc_o), .retire_instr_o(retire_instr_o),
        .wb_en_o(wb_en_o), .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
        .illegal_o(illegal_o), .halt_o(halt_o), .pc_o(pc_o)
    );

    bind rv32i_core rv32i_core_sva u_sva (
        .CLK(CLK), .rst_n_i(rst_n_i), .retire_o(retire_o), .wb_en_o(wb_en_o),
        .wb_rd_o(wb_rd_o), .illegal_o(illegal_o), .halt_o(halt_o)
    );

    function automatic logic [WORD_W-1:0] alu_ref(input logic [2:0] f3,
            input logic [WORD_W-1:0] a, input logic [WORD_W-1:0] b,
            input logic alt, input logic is_reg);
        case (f3)
            ADDSUB:  return (is_reg && alt) ? a - b : a + b;
            SLL:     return a << b[4:0];
            SLT:     return {31'b0, $signed(a) < $signed(b)};
            SLTU:    return {31'b0, a < b};
            XOR:     return a ^ b;
            SR:      return alt ? WORD_W'($signed(a) >>> b[4:0]) : a >> b[4:0];
            OR:      return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic int word_index(input logic [WORD_W-1:0] addr);
        return int'((addr >> 2) % DMEM_WORDS);
    endfunction

    // Executes one instruction on the model and returns what should retire
    function automatic exp_t ref_exec(input logic [WORD_W-1:0] ins);
        exp_t              e;
        logic [6:0]        op;
        logic [2:0]        f3;
        logic [WORD_W-1:0] a, b, imm_i, imm_s, imm_b, imm_j, imm_u, next;
        logic              taken;
        op    = ins[6:0];
        f3    = ins[14:12];
        a     = m_regs[ins[19:15]];
        b     = m_regs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        next  = m_pc + 4;
        e     = '0;
        e.pc  = m_pc;
        e.instr = ins;
        e.rd  = ins[11:7];
        case (op)
            LUI: begin
                e.wen  = 1'b1;
                e.data = imm_u;
            end
            AUIPC: begin
                e.wen  = 1'b1;
                e.data = m_pc + imm_u;
            end
            JAL: begin
                e.wen  = 1'b1;
                e.data = m_pc + 4;
                next   = m_pc + imm_j;
            end
            JALR: begin
                e.wen  = 1'b1;
                e.data = m_pc + 4;
                next   = (a + imm_i) & ~32'd1;
            end
            BRANCH: begin
                case (f3)
                    3'b000:  taken = a == b;
                    3'b001:  taken = a != b;
                    3'b100:  taken = $signed(a) < $signed(b);
                    3'b101:  taken = $signed(a) >= $signed(b);
                    3'b110:  taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) next = m_pc + imm_b;
            end
            LOAD: begin
                e.wen  = 1'b1;
                e.data = m_mem[word_index(a + imm_i)];
            end
            STORE:
                m_mem[word_index(a + imm_s)] = b;
            IMMED: begin
                e.wen  = 1'b1;
                e.data = alu_ref(f3, a, (f3 == SLLI || f3 == SRI) ? {27'b0, ins[24:20]} : imm_i,
                                 ins[30], 1'b0);
            end
            REGREG: begin
                e.illegal = ins[25];
                e.wen     = 1'b1;
                e.data    = alu_ref(f3, a, b, ins[30], 1'b1);
            end
            MISCMEM, SYSTEM: ;
            default:
                e.illegal = 1'b1;
        endcase
        e.wen  = e.wen && !e.illegal && (e.rd != '0);
        e.halt = (ins == 32'h0000006f);
        if (e.wen) m_regs[e.rd] = e.data;
        m_pc = next;
        if (e.halt) m_halted = 1'b1;
        return e;
    endfunction

    task automatic compare_word(input string what, input logic [WORD_W-1:0] got,
            input logic [WORD_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_reg(input string what, input logic [REG_ADDR_W-1:0] got,
            input logic [REG_ADDR_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is x%0d, expected x%0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Instruction encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, REGREG};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
    endfunction

    function automatic logic [4:0] rand_rd();
        return 5'(1 + $urandom % 31);
    endfunction

    task automatic send(input logic [WORD_W-1:0] ins);
        int gap;
        gap = $urandom % (MAX_GAP + 1);
        repeat (gap) begin
            @(posedge clk);
            instr_valid_i <= 1'b0;
        end
        @(posedge clk);
        instr_valid_i <= 1'b1;
        instr_i       <= ins;
        // Nothing retires once the model has halted
        if (!m_halted) exp_q.push_back(ref_exec(ins));
    endtask

    task automatic send_random_alu();
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        f3 = 3'($urandom);
        if ($urandom % 2) begin
            f7 = ((f3 == ADDSUB || f3 == SR) && ($urandom % 2)) ? 7'h20 : 7'h00;
            send(enc_r(f7, 5'($urandom), 5'($urandom), f3, rand_rd()));
        end else begin
            imm = 12'($urandom);
            if (f3 == SLLI) imm[11:5] = 7'h00;
            if (f3 == SRI) imm[11:5] = ($urandom % 2) ? 7'h20 : 7'h00;
            send(enc_i(imm, 5'($urandom), f3, rand_rd(), IMMED));
        end
    endtask

    task automatic run_tests();
        logic [6:0]  bad_ops [3];
        logic [4:0]  rs1, rd;
        logic [11:0] off;
        logic [2:0]  br_types [6];
        bad_ops  = '{7'b0000000, 7'b1111111, 7'b0101011};
        br_types = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        // Fill registers with random values
        for (int r = 1; r < 32; r++) begin
            send({20'($urandom), 5'(r), LUI});
            send(enc_i(12'($urandom), 5'(r), ADDI, 5'(r), IMMED));
        end
        repeat (N_ALU) send_random_alu();
        repeat (N_JMP) begin
            send({20'($urandom), rand_rd(), LUI});
            send({20'($urandom), rand_rd(), AUIPC});
            send(enc_j({20'($urandom), 1'b0}, rand_rd()));
            send(enc_i(12'($urandom), 5'($urandom), 3'b000, rand_rd(), JALR));
        end
        foreach (br_types[t]) begin
            repeat (N_BR) begin
                rs1 = 5'($urandom);
                send(enc_b({12'($urandom), 1'b0}, ($urandom % 3 == 0) ? rs1 : 5'($urandom),
                           rs1, br_types[t]));
            end
        end
        repeat (N_MEM) begin
            off = 12'(($urandom % DMEM_WORDS) * 4);
            rd  = rand_rd();
            send(enc_s(off, 5'($urandom), 5'd0));
            send(enc_i(off, 5'd0, 3'b010, rd, LOAD));
        end
        // x0 stays zero after a write attempt
        send(enc_i(12'h123, 5'd0, ADDI, 5'd0, IMMED));
        send(enc_r(7'h00, 5'd0, 5'd0, ADDSUB, rand_rd()));
        repeat (N_ILL) begin
            send({25'($urandom), bad_ops[$urandom % 3]});
            send(enc_r(7'h01, 5'($urandom), 5'($urandom), 3'($urandom), rand_rd()));
        end
        send(32'h0000006f);
        repeat (5) send_random_alu();
    endtask

    // Retire checker, sampled away from the driving edge
    always @(negedge clk) begin
        exp_t e;
        if (rst_n && retire_o) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Unexpected retire of instruction %h at %0t", retire_instr_o, $time);
            end else begin
                e = exp_q.pop_front();
                compare_word("retire_pc_o", retire_pc_o, e.pc);
                compare_word("retire_instr_o", retire_instr_o, e.instr);
                compare_bit("wb_en_o", wb_en_o, e.wen);
                compare_bit("illegal_o", illegal_o, e.illegal);
                compare_bit("halt_o", halt_o, e.halt);
                if (e.wen) begin
                    compare_reg("wb_rd_o", wb_rd_o, e.rd);
                    compare_word("wb_data_o", wb_data_o, e.data);
                end
            end
        end
    end

    initial begin
        #(RUN_LIMIT);
        $display("Timeout: the run took too long, %0d retires never arrived", exp_q.size());
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        instr_valid_i = 1'b0;
        instr_i       = '0;
        errors        = 0;
        m_pc          = RESET_PC;
        m_halted      = 1'b0;
        foreach (m_regs[r]) m_regs[r] = '0;
        void'($urandom(SEED));
        @(posedge rst_n);
        @(negedge clk);
        compare_word("pc_o after reset", pc_o, RESET_PC);
        compare_bit("halt_o after reset", halt_o, 1'b0);
        run_tests();
        @(posedge clk);
        instr_valid_i <= 1'b0;
        while (exp_q.size() != 0) @(posedge clk);
        // Leave room for any stray retire
        repeat (5) @(posedge clk);
        compare_bit("halt_o at end", halt_o, 1'b1);
        $display("Run complete, %0d errors", errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* tb/rv32i_core_sva.sv */
`timescale 1ns/1ps

module rv32i_core_sva import rv32i_pkg::*; (
    input logic                  CLK,
    input logic                  rst_n_i,
    input logic                  retire_o,
    input logic                  wb_en_o,
    input logic [REG_ADDR_W-1:0] wb_rd_o,
    input logic                  illegal_o,
    input logic                  halt_o
);

    // x0 is never reported as written
    wb_rd_nonzero: assert property (@(posedge CLK) disable iff (!rst_n_i)
        wb_en_o |-> wb_rd_o != '0)
        else $error("Write-back reported to x0");

    illegal_no_write: assert property (@(posedge CLK) disable iff (!rst_n_i)
        illegal_o |-> !wb_en_o)
        else $error("Illegal instruction wrote a register");

    // The j 0 itself retires with halt_o, nothing after it
    halted_no_retire: assert property (@(posedge CLK) disable iff (!rst_n_i)
        (halt_o && $past(halt_o)) |-> !retire_o)
        else $error("Retire seen while halted");

endmodule

/* tb/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen #(
    parameter time PERIOD      = 40ns,
    parameter int  RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Reset released on a rising edge, as the core samples it synchronously
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

/* logic/rv32i_core.sv */
`timescale 1ns/1ps

module rv32i_core import rv32i_pkg::*; #(
    parameter logic [WORD_W-1:0] RESET_PC            = '0,
    parameter int                DMEM_WORDS          = 256,
    parameter bit                INFINITE_LOOP_HALTS = 1'b1
) (
    input  logic                  CLK,
    input  logic                  rst_n_i,
    input  logic                  instr_valid_i,
    input  logic [WORD_W-1:0]     instr_i,
    output logic                  retire_o,
    output logic [WORD_W-1:0]     retire_pc_o,
    output logic [WORD_W-1:0]     retire_instr_o,
    output logic                  wb_en_o,
    output logic [REG_ADDR_W-1:0] wb_rd_o,
    output logic [WORD_W-1:0]     wb_data_o,
    output logic                  illegal_o,
    output logic                  halt_o,
    output logic [WORD_W-1:0]     pc_o
);

    logic [REG_ADDR_W-1:0] rs1, rs2, rd;
    logic [WORD_W-1:0]     imm_i, imm_s, imm_sb, imm_uj, imm_u, imm_i_sh;
    logic                  imm_shamt_sel, wen, dwen, dren, branch, jump, j_sel;
    logic                  illegal, halt;
    logic [1:0]            alu_a_sel, alu_b_sel;
    alu_op_t               alu_op;
    w_sel_t                w_sel;
    branch_t               branch_type;
    logic [WORD_W-1:0]     rs1_data, rs2_data, alu_a, alu_b, alu_result;
    logic [WORD_W-1:0]     dram_rdata, dload_data, pc_plus4, wb_data;
    logic                  accept, rf_wen, dram_wen;

    control_unit #(.INFINITE_LOOP_HALTS(INFINITE_LOOP_HALTS)) u_ctrl (
        .instr_i(instr_i), .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd),
        .imm_i_o(imm_i), .imm_s_o(imm_s), .imm_sb_o(imm_sb), .imm_uj_o(imm_uj),
        .imm_u_o(imm_u), .imm_shamt_sel_o(imm_shamt_sel),
        .alu_a_sel_o(alu_a_sel), .alu_b_sel_o(alu_b_sel), .alu_op_o(alu_op),
        .w_sel_o(w_sel), .wen_o(wen), .dwen_o(dwen), .dren_o(dren),
        .branch_o(branch), .branch_type_o(branch_type), .jump_o(jump),
        .j_sel_o(j_sel), .illegal_o(illegal), .halt_o(halt)
    );

    // Nothing executes once halted
    assign accept   = instr_valid_i && !halt_o;
    assign rf_wen   = accept && wen && !illegal && (rd != '0);
    assign dram_wen = accept && dwen && !illegal;

    reg_file u_rf (
        .CLK(CLK), .rst_n_i(rst_n_i), .wen_i(rf_wen), .waddr_i(rd), .wdata_i(wb_data),
        .raddr1_i(rs1), .raddr2_i(rs2), .rdata1_o(rs1_data), .rdata2_o(rs2_data)
    );

    // Shift amount sits in the rs2 field
    assign imm_i_sh = imm_shamt_sel ? {{(WORD_W-REG_ADDR_W){1'b0}}, rs2} : imm_i;

    always_comb begin
        case (alu_a_sel)
            2'd0, 2'd1: alu_a = rs1_data;
            default:    alu_a = pc_o;
        endcase
        case (alu_b_sel)
            2'd0:    alu_b = imm_s;
            2'd1:    alu_b = rs2_data;
            2'd2:    alu_b = imm_i_sh;
            default: alu_b = imm_u;
        endcase
    end

    alu u_alu (.a_i(alu_a), .b_i(alu_b), .op_i(alu_op), .result_o(alu_result));

    pc_unit #(.RESET_PC(RESET_PC)) u_pc (
        .CLK(CLK), .rst_n_i(rst_n_i), .advance_i(accept), .branch_i(branch),
        .branch_type_i(branch_type), .jump_i(jump), .j_sel_i(j_sel),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .imm_sb_i(imm_sb),
        .imm_uj_i(imm_uj), .imm_i_i(imm_i), .pc_o(pc_o), .pc_plus4_o(pc_plus4)
    );

    // Address comes from rs1 plus offset through the ALU
    data_ram #(.DMEM_WORDS(DMEM_WORDS)) u_dram (
        .CLK(CLK), .wen_i(dram_wen), .addr_i(alu_result), .wdata_i(rs2_data),
        .rdata_o(dram_rdata)
    );

    assign dload_data = dren ? dram_rdata : '0;

    always_comb begin
        case (w_sel)
            W_SEL_FROM_ALU:   wb_data = alu_result;
            W_SEL_FROM_DLOAD: wb_data = dload_data;
            W_SEL_FROM_PC:    wb_data = pc_plus4;
            default:          wb_data = imm_u;
        endcase
    end

    // Retire status, cleared by reset
    always_ff @(posedge CLK) begin
        if (!rst_n_i) begin
            retire_o  <= 1'b0;
            wb_en_o   <= 1'b0;
            illegal_o <= 1'b0;
            halt_o    <= 1'b0;
        end else begin
            retire_o  <= accept;
            wb_en_o   <= rf_wen;
            illegal_o <= accept && illegal;
            if (accept && halt) begin
                halt_o <= 1'b1;
            end
        end
    end

    // Retire payload
    always_ff @(posedge CLK) begin
        if (accept) begin
            retire_pc_o    <= pc_o;
            retire_instr_o <= instr_i;
            wb_rd_o        <= rd;
            wb_data_o      <= wb_data;
        end
    end

endmodule

/* logic/data_ram.sv */
`timescale 1ns/1ps

module data_ram import rv32i_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  logic              CLK,
    input  logic              wen_i,
    input  logic [WORD_W-1:0] addr_i,
    input  logic [WORD_W-1:0] wdata_i,
    output logic [WORD_W-1:0] rdata_o
);

    localparam int IDX_W = $clog2(DMEM_WORDS);

    logic [WORD_W-1:0] mem [DMEM_WORDS];
    logic [IDX_W-1:0]  idx;

    // Word index, upper address bits wrap around
    assign idx = addr_i[IDX_W+1:2];

    always_ff @(posedge CLK) begin
        if (wen_i) begin
            mem[idx] <= wdata_i;
        end
    end

    assign rdata_o = mem[idx];

endmodule

/* logic/pc_unit.sv */
`timescale 1ns/1ps

module pc_unit import rv32i_pkg::*; #(
    parameter logic [WORD_W-1:0] RESET_PC = '0
) (
    input  logic              CLK,
    input  logic              rst_n_i,
    input  logic              advance_i,
    input  logic              branch_i,
    input  branch_t           branch_type_i,
    input  logic              jump_i,
    input  logic              j_sel_i,
    input  logic [WORD_W-1:0] rs1_data_i,
    input  logic [WORD_W-1:0] rs2_data_i,
    input  logic [WORD_W-1:0] imm_sb_i,
    input  logic [WORD_W-1:0] imm_uj_i,
    input  logic [WORD_W-1:0] imm_i_i,
    output logic [WORD_W-1:0] pc_o,
    output logic [WORD_W-1:0] pc_plus4_o
);

    logic              taken;
    logic [WORD_W-1:0] jalr_target;
    logic [WORD_W-1:0] next_pc;

    always_comb begin
        case (branch_type_i)
            BEQ:     taken = (rs1_data_i == rs2_data_i);
            BNE:     taken = (rs1_data_i != rs2_data_i);
            BLT:     taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
            BGE:     taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            BLTU:    taken = (rs1_data_i < rs2_data_i);
            BGEU:    taken = (rs1_data_i >= rs2_data_i);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4_o  = pc_o + 32'd4;
    // JALR clears bit 0 of the sum
    assign jalr_target = (rs1_data_i + imm_i_i) & ~32'd1;

    always_comb begin
        if (jump_i && j_sel_i)       next_pc = pc_o + imm_uj_i;
        else if (jump_i)             next_pc = jalr_target;
        else if (branch_i && taken)  next_pc = pc_o + imm_sb_i;
        else                         next_pc = pc_plus4_o;
    end

    always_ff @(posedge CLK) begin
        if (!rst_n_i) begin
            pc_o <= RESET_PC;
        end else if (advance_i) begin
            pc_o <= next_pc;
        end
    end

endmodule

/* logic/reg_file.sv */
`timescale 1ns/1ps

module reg_file import rv32i_pkg::*; (
    input  logic                  CLK,
    input  logic                  rst_n_i,
    input  logic                  wen_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [WORD_W-1:0]     wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [WORD_W-1:0]     rdata1_o,
    output logic [WORD_W-1:0]     rdata2_o
);

    // x0 has no storage
    logic [WORD_W-1:0] regs [1:31];

    always_ff @(posedge CLK) begin
        if (!rst_n_i) begin
            regs <= '{default: '0};
        end else if (wen_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // No write-to-read bypass
    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

/* logic/alu.sv */
`timescale 1ns/1ps

module alu import rv32i_pkg::*; (
    input  logic [WORD_W-1:0] a_i,
    input  logic [WORD_W-1:0] b_i,
    input  alu_op_t           op_i,
    output logic [WORD_W-1:0] result_o
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // Only the low five bits count for a shift
    assign shamt       = b_i[4:0];
    assign lt_signed   = $signed(a_i) < $signed(b_i);
    assign lt_unsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SUB:  result_o = a_i - b_i;
            ALU_SLL:  result_o = a_i << shamt;
            ALU_SRL:  result_o = a_i >> shamt;
            ALU_SRA:  result_o = $signed(a_i) >>> shamt;
            ALU_AND:  result_o = a_i & b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_SLT:  result_o = {{(WORD_W-1){1'b0}}, lt_signed};
            ALU_SLTU: result_o = {{(WORD_W-1){1'b0}}, lt_unsigned};
            default:  result_o = a_i + b_i;
        endcase
    end

endmodule

/* logic/control_unit.sv */
`timescale 1ns/1ps

module control_unit import rv32i_pkg::*; #(
    parameter bit INFINITE_LOOP_HALTS = 1'b1
) (
    input  logic [WORD_W-1:0]     instr_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic [REG_ADDR_W-1:0] rd_o,
    output logic [WORD_W-1:0]     imm_i_o,
    output logic [WORD_W-1:0]     imm_s_o,
    output logic [WORD_W-1:0]     imm_sb_o,
    output logic [WORD_W-1:0]     imm_uj_o,
    output logic [WORD_W-1:0]     imm_u_o,
    output logic                  imm_shamt_sel_o,
    output logic [1:0]            alu_a_sel_o,
    output logic [1:0]            alu_b_sel_o,
    output alu_op_t               alu_op_o,
    output w_sel_t                w_sel_o,
    output logic                  wen_o,
    output logic                  dwen_o,
    output logic                  dren_o,
    output logic                  branch_o,
    output branch_t               branch_type_o,
    output logic                  jump_o,
    output logic                  j_sel_o,
    output logic                  illegal_o,
    output logic                  halt_o
);

    opcode_t               opcode;
    logic [FUNCT3_W-1:0]   funct3;
    logic [FUNCT7_W-1:0]   funct7;
    logic                  is_imm;
    logic                  is_reg;
    logic                  sr;
    logic                  op_sll, op_sra, op_srl, op_add, op_sub;
    logic                  op_and, op_or, op_xor, op_slt, op_sltu;

    assign opcode = opcode_t'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign is_imm = (opcode == IMMED);
    assign is_reg = (opcode == REGREG);

    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];
    assign rd_o  = instr_i[11:7];

    // Sign-extended immediates for each format
    assign imm_i_o  = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_o  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_sb_o = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                       instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_uj_o = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                       instr_i[20], instr_i[30:21], 1'b0};
    assign imm_u_o  = {instr_i[31:12], 12'b0};

    assign imm_shamt_sel_o = is_imm && (funct3 == SLLI || funct3 == SRI);

    assign dwen_o        = (opcode == STORE);
    assign dren_o        = (opcode == LOAD);
    assign branch_o      = (opcode == BRANCH);
    assign branch_type_o = branch_t'(funct3);
    assign jump_o        = (opcode == JAL) || (opcode == JALR);
    assign j_sel_o       = (opcode == JAL);

    // Operand A: 0 and 1 pick rs1, 2 picks the PC
    always_comb begin
        case (opcode)
            REGREG, IMMED, LOAD: alu_a_sel_o = 2'd0;
            STORE:               alu_a_sel_o = 2'd1;
            default:             alu_a_sel_o = 2'd2;
        endcase
    end

    // Operand B: store imm, rs2, I imm, U imm
    always_comb begin
        case (opcode)
            STORE:       alu_b_sel_o = 2'd0;
            IMMED, LOAD: alu_b_sel_o = 2'd2;
            AUIPC:       alu_b_sel_o = 2'd3;
            default:     alu_b_sel_o = 2'd1;
        endcase
    end

    always_comb begin
        case (opcode)
            JAL, JALR:            w_sel_o = W_SEL_FROM_PC;
            LUI:                  w_sel_o = W_SEL_FROM_IMM_U;
            IMMED, AUIPC, REGREG: w_sel_o = W_SEL_FROM_ALU;
            default:              w_sel_o = W_SEL_FROM_DLOAD;
        endcase
    end

    always_comb begin
        case (opcode)
            IMMED, LUI, AUIPC, REGREG, JAL, JALR, LOAD: wen_o = 1'b1;
            default:                                    wen_o = 1'b0;
        endcase
    end

    // Per-operation match terms
    assign sr      = (is_imm && funct3 == SRI) || (is_reg && funct3 == SR);
    assign op_sll  = (is_imm && funct3 == SLLI) || (is_reg && funct3 == SLL);
    assign op_sra  = sr && instr_i[30];
    assign op_srl  = sr && !instr_i[30];
    assign op_add  = (is_imm && funct3 == ADDI) || (opcode == AUIPC)
                   || (is_reg && funct3 == ADDSUB && !instr_i[30])
                   || (opcode == LOAD) || (opcode == STORE);
    assign op_sub  = is_reg && funct3 == ADDSUB && instr_i[30];
    assign op_and  = (is_imm && funct3 == ANDI) || (is_reg && funct3 == AND);
    assign op_or   = (is_imm && funct3 == ORI) || (is_reg && funct3 == OR);
    assign op_xor  = (is_imm && funct3 == XORI) || (is_reg && funct3 == XOR);
    assign op_slt  = (is_imm && funct3 == SLTI) || (is_reg && funct3 == SLT);
    assign op_sltu = (is_imm && funct3 == SLTIU) || (is_reg && funct3 == SLTU);

    // Shifts win over add, add over sub, and so on
    always_comb begin
        if (op_sll)       alu_op_o = ALU_SLL;
        else if (op_sra)  alu_op_o = ALU_SRA;
        else if (op_srl)  alu_op_o = ALU_SRL;
        else if (op_add)  alu_op_o = ALU_ADD;
        else if (op_sub)  alu_op_o = ALU_SUB;
        else if (op_and)  alu_op_o = ALU_AND;
        else if (op_or)   alu_op_o = ALU_OR;
        else if (op_xor)  alu_op_o = ALU_XOR;
        else if (op_slt)  alu_op_o = ALU_SLT;
        else if (op_sltu) alu_op_o = ALU_SLTU;
        else              alu_op_o = ALU_ADD;
    end

    // funct7 bit 0 on OP would be an M-extension encoding
    always_comb begin
        case (opcode)
            REGREG:                                 illegal_o = funct7[0];
            LUI, AUIPC, JAL, JALR, BRANCH, LOAD,
            STORE, IMMED, MISCMEM, SYSTEM:          illegal_o = 1'b0;
            default:                                illegal_o = 1'b1;
        endcase
    end

    // Stop on "j 0", the usual end-of-test idiom
    if (INFINITE_LOOP_HALTS) begin : g_halt
        assign halt_o = (instr_i == 32'h0000006f);
    end else begin : g_no_halt
        assign halt_o = 1'b0;
    end

endmodule

/* logic/rv32i_pkg.sv */
package rv32i_pkg;

    // Instruction field and datapath widths
    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT7_W   = 7;

    // Major opcodes of the RV32I base set
    typedef enum logic [OPCODE_W-1:0] {
        LUI     = 7'b0110111,
        AUIPC   = 7'b0010111,
        JAL     = 7'b1101111,
        JALR    = 7'b1100111,
        BRANCH  = 7'b1100011,
        LOAD    = 7'b0000011,
        STORE   = 7'b0100011,
        IMMED   = 7'b0010011,
        REGREG  = 7'b0110011,
        MISCMEM = 7'b0001111,
        SYSTEM  = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
    } alu_op_t;

    typedef enum logic [1:0] {
        W_SEL_FROM_ALU   = 2'd0,
        W_SEL_FROM_DLOAD = 2'd1,
        W_SEL_FROM_PC    = 2'd2,
        W_SEL_FROM_IMM_U = 2'd3
    } w_sel_t;

    // Encoded as the branch funct3 field
    typedef enum logic [FUNCT3_W-1:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_t;

    // funct3 for OP-IMM
    localparam logic [FUNCT3_W-1:0] ADDI  = 3'b000;
    localparam logic [FUNCT3_W-1:0] SLLI  = 3'b001;
    localparam logic [FUNCT3_W-1:0] SLTI  = 3'b010;
    localparam logic [FUNCT3_W-1:0] SLTIU = 3'b011;
    localparam logic [FUNCT3_W-1:0] XORI  = 3'b100;
    localparam logic [FUNCT3_W-1:0] SRI   = 3'b101;
    localparam logic [FUNCT3_W-1:0] ORI   = 3'b110;
    localparam logic [FUNCT3_W-1:0] ANDI  = 3'b111;

    // funct3 for OP
    localparam logic [FUNCT3_W-1:0] ADDSUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] SLL    = 3'b001;
    localparam logic [FUNCT3_W-1:0] SLT    = 3'b010;
    localparam logic [FUNCT3_W-1:0] SLTU   = 3'b011;
    localparam logic [FUNCT3_W-1:0] XOR    = 3'b100;
    localparam logic [FUNCT3_W-1:0] SR     = 3'b101;
    localparam logic [FUNCT3_W-1:0] OR     = 3'b110;
    localparam logic [FUNCT3_W-1:0] AND    = 3'b111;

endpackage
